//--- verilog/soc_map_pkg.sv
/* Peripheral address map */
`default_nettype none

package soc_map_pkg;

    // ------------------------------
    // RAM banks
    // ------------------------------

    // Scratch RAM split into equal banks
    localparam int num_ram_banks  = 4;
    localparam int bank_addr_bits = 8;
    localparam int bank_words     = 2 ** bank_addr_bits;
    localparam int bank_sel_bits  = $clog2(num_ram_banks);

    // Byte offset bits covered by the whole RAM window
    localparam int ram_span_bits  = bank_addr_bits + bank_sel_bits + 2;

    // Banks lie back to back from here
    localparam logic [31:0] ram_base = 32'h0001_0000;

    // ------------------------------
    // Other slots
    // ------------------------------

    localparam logic [31:0] led_fb_addr = 32'h0002_0000;

    // Framebuffer sits right after the banks
    localparam int led_slot  = num_ram_banks;
    localparam int num_slots = num_ram_banks + 1;

endpackage

`default_nettype wire

//--- verilog/iomem_pkg.sv
/* Memory bus field types */
`default_nettype none

package iomem_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------

    localparam int addr_bits = 32;
    localparam int data_bits = 32;
    localparam int strb_bits = data_bits / 8;
    localparam int slot_bits = 3;

    // ------------------------------
    // Field types
    // ------------------------------

    // Byte address
    typedef logic [addr_bits-1:0] addr_t;

    // Bus word
    typedef logic [data_bits-1:0] data_t;

    // One bit per byte lane, all zero for a read
    typedef logic [strb_bits-1:0] strb_t;

    // Slot number behind the decoder
    typedef logic [slot_bits-1:0] slot_idx_t;

endpackage

`default_nettype wire

//--- verilog/iomem_if.sv
/* Slot request and response bus */
`default_nettype none

interface iomem_if;
    import iomem_pkg::*;

    // Request, driven by the decoder
    logic  valid;
    strb_t wstrb;
    addr_t addr;
    data_t wdata;

    // Response, driven by the slot
    logic  ready;
    data_t rdata;

    modport decoder (
        output valid,
        output wstrb,
        output addr,
        output wdata
    );

    modport slot (
        input  valid,
        input  wstrb,
        input  addr,
        input  wdata,
        output ready,
        output rdata
    );

    // Merger only looks at the response side
    modport merge (
        input ready,
        input rdata
    );

endinterface

`default_nettype wire

//--- verilog/iomem_decoder.sv
/* Bus address decoder */
`default_nettype none

module iomem_decoder (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   iomem_valid,
    input  wire iomem_pkg::strb_t iomem_wstrb,
    input  wire iomem_pkg::addr_t iomem_addr,
    input  wire iomem_pkg::data_t iomem_wdata,
    iomem_if.decoder              slots [soc_map_pkg::num_slots],
    output logic                  miss_ready
);
    import iomem_pkg::*;
    import soc_map_pkg::*;

    logic                     in_ram;
    logic                     in_led;
    logic                     hit;
    logic                     miss;
    logic [bank_sel_bits-1:0] bank_sel;
    slot_idx_t                hit_slot;
    addr_t                    word_idx;

    // ------------------------------
    // Address compare
    // ------------------------------

    // RAM window is aligned, so only the upper bits need to match
    assign in_ram = iomem_addr[addr_bits-1:ram_span_bits] ==
                    ram_base[addr_bits-1:ram_span_bits];
    assign in_led = iomem_addr == led_fb_addr;
    assign hit    = in_ram || in_led;

    // Bank number sits just above the word index
    assign bank_sel = iomem_addr[ram_span_bits-1 -: bank_sel_bits];

    // Word index inside a bank, byte lanes dropped
    assign word_idx = addr_t'(iomem_addr[bank_addr_bits+1:2]);

    always_comb begin
        if (in_ram) begin
            hit_slot = slot_idx_t'(bank_sel);
        end else begin
            hit_slot = slot_idx_t'(led_slot);
        end
    end

    // ------------------------------
    // Slot requests
    // ------------------------------

    for (genvar i = 0; i < num_slots; i++) begin : g_slot
        assign slots[i].valid = iomem_valid && hit && (hit_slot == slot_idx_t'(i));
        assign slots[i].wstrb = iomem_wstrb;
        assign slots[i].addr  = word_idx;
        assign slots[i].wdata = iomem_wdata;
    end

    // ------------------------------
    // Unmapped addresses
    // ------------------------------

    assign miss = iomem_valid && !hit;

    // One pulse per request, the pulse itself blocks a second one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            miss_ready <= 1'b0;
        end else begin
            miss_ready <= miss && !miss_ready;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ram_bank.sv
/* Scratch RAM bank */
`default_nettype none

module ram_bank (
    input  wire   clk,
    input  wire   rst_n,
    iomem_if.slot bus
);
    import iomem_pkg::*;
    import soc_map_pkg::*;

    data_t                     mem [bank_words];
    logic [bank_addr_bits-1:0] idx;
    logic                      take;
    logic                      is_read;

    // ------------------------------
    // Request qualify
    // ------------------------------

    assign idx     = bus.addr[bank_addr_bits-1:0];
    assign is_read = bus.wstrb == '0;

    // Valid stays up during the ready cycle, so ignore it then
    assign take = bus.valid && !bus.ready;

    // ------------------------------
    // Storage
    // ------------------------------

    // Byte lanes written one by one
    always_ff @(posedge clk) begin
        if (take) begin
            for (int b = 0; b < strb_bits; b++) begin
                if (bus.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Response
    // ------------------------------

    always_ff @(posedge clk) begin
        if (take) begin
            if (is_read) begin
                bus.rdata <= mem[idx];
            end else begin
                bus.rdata <= '0;
            end
        end
    end

    // One cycle pulse per accepted request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= take;
        end
    end

endmodule

`default_nettype wire

//--- verilog/led_fb_reg.sv
/* LED framebuffer register */
`default_nettype none

module led_fb_reg (
    input  wire                   clk,
    input  wire                   rst_n,
    iomem_if.slot                 bus,
    output iomem_pkg::data_t      led_fb
);
    import iomem_pkg::*;

    data_t fb;
    logic  take;
    logic  is_write;

    assign take     = bus.valid && !bus.ready;
    assign is_write = |bus.wstrb;

    // Any strobe bit writes the full word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fb        <= '0;
            bus.ready <= 1'b0;
        end else begin
            if (take && is_write) begin
                fb <= bus.wdata;
            end
            bus.ready <= take;
        end
    end

    // Read returns the stored word, write returns zero
    always_ff @(posedge clk) begin
        if (take) begin
            bus.rdata <= is_write ? '0 : fb;
        end
    end

    assign led_fb = fb;

endmodule

`default_nettype wire

//--- verilog/iomem_resp_merge.sv
/* Slot response merger */
`default_nettype none

module iomem_resp_merge (
    iomem_if.merge           slots [soc_map_pkg::num_slots],
    input  wire              miss_ready,
    output logic             iomem_ready,
    output iomem_pkg::data_t iomem_rdata
);
    import iomem_pkg::*;
    import soc_map_pkg::*;

    logic [num_slots-1:0] slot_ready;
    data_t                slot_rdata [num_slots];

    // ------------------------------
    // Gather slot responses
    // ------------------------------

    // Interface arrays only take constant indices
    for (genvar i = 0; i < num_slots; i++) begin : g_gather
        assign slot_ready[i] = slots[i].ready;
        assign slot_rdata[i] = slots[i].rdata;
    end

    // ------------------------------
    // Merge
    // ------------------------------

    // Miss pulse answers unmapped requests
    assign iomem_ready = (|slot_ready) || miss_ready;

    // At most one slot answers, so an AND-OR mux is enough.
    // A miss leaves the data at zero.
    always_comb begin
        iomem_rdata = '0;
        for (int i = 0; i < num_slots; i++) begin
            iomem_rdata = iomem_rdata | (slot_rdata[i] & {data_bits{slot_ready[i]}});
        end
    end

endmodule

`default_nettype wire

//--- verilog/soc_iomem.sv
/* Memory-mapped peripheral subsystem */
`default_nettype none

module soc_iomem (
    input  wire                   clk,
    input  wire                   rst_n,

    // Master request
    input  wire                   iomem_valid,
    input  wire iomem_pkg::strb_t iomem_wstrb,
    input  wire iomem_pkg::addr_t iomem_addr,
    input  wire iomem_pkg::data_t iomem_wdata,

    // Master response
    output logic                  iomem_ready,
    output iomem_pkg::data_t      iomem_rdata,

    // LED framebuffer contents
    output iomem_pkg::data_t      led_fb
);
    import soc_map_pkg::*;

    logic miss_ready;

    // One bus per slot, banks first then the framebuffer
    iomem_if slot_bus [num_slots] ();

    // ------------------------------
    // Decode
    // ------------------------------

    iomem_decoder iomem_decoder_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .slots       (slot_bus),
        .miss_ready  (miss_ready)
    );

    // ------------------------------
    // Slots
    // ------------------------------

    for (genvar i = 0; i < num_ram_banks; i++) begin : g_bank
        ram_bank ram_bank_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .bus   (slot_bus[i])
        );
    end

    led_fb_reg led_fb_reg_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (slot_bus[led_slot]),
        .led_fb (led_fb)
    );

    // ------------------------------
    // Response
    // ------------------------------

    iomem_resp_merge iomem_resp_merge_inst (
        .slots       (slot_bus),
        .miss_ready  (miss_ready),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata)
    );

endmodule

`default_nettype wire

//--- bench/soc_iomem_checker.sv
/* Bus response checker */
`default_nettype none

module soc_iomem_checker (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   iomem_valid,
    input  wire iomem_pkg::strb_t iomem_wstrb,
    input  wire iomem_pkg::addr_t iomem_addr,
    input  wire iomem_pkg::data_t iomem_wdata,
    input  wire                   iomem_ready,
    input  wire iomem_pkg::data_t iomem_rdata,
    input  wire iomem_pkg::data_t led_fb,
    input  wire                   exp_check,
    input  wire iomem_pkg::data_t exp_rdata,
    output int                    errors
);
    import iomem_pkg::*;
    import soc_map_pkg::*;

    localparam logic [31:0] ram_end = ram_base + num_ram_banks * bank_words * 4;

    // Unwritten RAM bytes stay x and are not compared
    logic [31:0] shadow [addr_t];
    data_t       shadow_led;
    int          wait_cycles;

    initial errors = 0;

    function automatic bit is_ram(input addr_t a);
        return (a >= ram_base) && (a < ram_end);
    endfunction

    function automatic logic [31:0] model_read(input addr_t a);
        addr_t key;
        key = {a[31:2], 2'b00};
        if (is_ram(a)) begin
            return shadow.exists(key) ? shadow[key] : 32'hx;
        end else if (a == led_fb_addr) begin
            return shadow_led;
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at time %0t: %s", $time, msg);
        errors++;
    endtask

    // Byte merge, the framebuffer takes the whole word
    task automatic model_write(input addr_t a, input strb_t s, input data_t d);
        addr_t       key;
        logic [31:0] w;
        key = {a[31:2], 2'b00};
        if (is_ram(a)) begin
            w = shadow.exists(key) ? shadow[key] : 32'hx;
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    w[8*b +: 8] = d[8*b +: 8];
                end
            end
            shadow[key] = w;
        end else if (a == led_fb_addr) begin
            shadow_led = d;
        end
    endtask

    task automatic check_response();
        logic [31:0] exp;
        bit          bad;
        bad = 1'b0;
        if (iomem_wstrb == '0) begin
            exp = model_read(iomem_addr);
            for (int b = 0; b < 4; b++) begin
                if (!$isunknown(exp[8*b +: 8]) && iomem_rdata[8*b +: 8] !== exp[8*b +: 8]) begin
                    bad = 1'b1;
                end
            end
            if (bad) begin
                report_mismatch($sformatf("read %h returned %h, model holds %h",
                                          iomem_addr, iomem_rdata, exp));
            end
        end else begin
            if (iomem_rdata !== '0) begin
                report_mismatch($sformatf("write %h returned data %h instead of zero",
                                          iomem_addr, iomem_rdata));
            end
            model_write(iomem_addr, iomem_wstrb, iomem_wdata);
        end
        if (exp_check && iomem_rdata !== exp_rdata) begin
            report_mismatch($sformatf("access %h returned %h, table expects %h",
                                      iomem_addr, iomem_rdata, exp_rdata));
        end
    endtask

    // ------------------------------
    // Response watch
    // ------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            shadow_led  = '0;
            wait_cycles = 0;
        end else begin
            if (iomem_ready && !iomem_valid) begin
                report_failure("ready seen without a pending request");
            end else if (iomem_valid && !iomem_ready) begin
                wait_cycles++;
            end else if (iomem_valid && iomem_ready) begin
                if (wait_cycles != 1) begin
                    report_failure($sformatf("ready came %0d cycles after the request, not 1",
                                             wait_cycles));
                end
                wait_cycles = 0;
                check_response();
            end
            if (led_fb !== shadow_led) begin
                report_mismatch($sformatf("led_fb shows %h, model holds %h", led_fb, shadow_led));
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/soc_iomem_assert.sv
/* Handshake assertions */
`default_nettype none

module soc_iomem_assert (
    input wire                                clk,
    input wire                                rst_n,
    input wire                                iomem_valid,
    input wire                                iomem_ready,
    input wire                                miss_ready,
    input wire [soc_map_pkg::num_slots-1:0]   slot_ready
);
    int assert_errors = 0;

    // Ready is a single cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        iomem_ready |=> !iomem_ready)
        else begin
            $error("iomem_ready high two cycles in a row");
            assert_errors++;
        end

    // At most one responder per cycle
    a_one_responder: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({slot_ready, miss_ready}))
        else begin
            $error("more than one slot answered at once");
            assert_errors++;
        end

    // New request answered on the next cycle
    a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
        iomem_valid && !iomem_ready |=> iomem_ready)
        else begin
            $error("request not answered after one cycle");
            assert_errors++;
        end

endmodule

bind soc_iomem soc_iomem_assert soc_iomem_assert_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .iomem_valid (iomem_valid),
    .iomem_ready (iomem_ready),
    .miss_ready  (miss_ready),
    .slot_ready  (iomem_resp_merge_inst.slot_ready)
);

`default_nettype wire

//--- bench/tb_soc_iomem.sv
/* Peripheral subsystem testbench */
`default_nettype none

module tb_soc_iomem;
    import iomem_pkg::*;
    import soc_map_pkg::*;

    localparam int          num_random      = 8;
    localparam int          margin_cycles   = 40;
    localparam int          max_wait_cycles = 8;
    localparam logic [31:0] lcg_seed        = 32'ha17d;
    localparam int          bank_stride     = bank_words * 4;

    typedef struct {
        addr_t addr;
        strb_t wstrb;
        data_t wdata;
        data_t rdata;
        bit    check;
    } test_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  iomem_valid;
    strb_t iomem_wstrb;
    addr_t iomem_addr;
    data_t iomem_wdata;
    logic  iomem_ready;
    data_t iomem_rdata;
    data_t led_fb;
    logic  exp_check;
    data_t exp_rdata;
    int    checker_errors;
    test_t tests [$];
    bit    table_built = 1'b0;
    int    fail_count  = 0;

    always #2 clk = ~clk;

    soc_iomem soc_iomem_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata),
        .led_fb      (led_fb)
    );

    soc_iomem_checker soc_iomem_checker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .iomem_valid (iomem_valid),
        .iomem_wstrb (iomem_wstrb),
        .iomem_addr  (iomem_addr),
        .iomem_wdata (iomem_wdata),
        .iomem_ready (iomem_ready),
        .iomem_rdata (iomem_rdata),
        .led_fb      (led_fb),
        .exp_check   (exp_check),
        .exp_rdata   (exp_rdata),
        .errors      (checker_errors)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Checker and assertion failures together
    function automatic int error_total();
        return checker_errors + soc_iomem_inst.soc_iomem_assert_inst.assert_errors;
    endfunction

    function automatic void add_entry(addr_t a, strb_t s, data_t w, data_t r, bit chk);
        test_t t;
        t.addr  = a;
        t.wstrb = s;
        t.wdata = w;
        t.rdata = r;
        t.check = chk;
        tests.push_back(t);
    endfunction

    // ------------------------------
    // Stimulus table
    // ------------------------------

    task automatic build_table();
        logic [31:0] state;
        addr_t       rand_addr [num_random];
        state = lcg_seed;
        // Framebuffer straight after reset
        add_entry(led_fb_addr, 4'b0000, '0, '0, 1'b1);
        // Same index in every bank, then read back
        for (int b = 0; b < num_ram_banks; b++) begin
            add_entry(ram_base + b * bank_stride + 32'h10, 4'hf, 32'hcafe_0000 + b, '0, 1'b1);
        end
        for (int b = 0; b < num_ram_banks; b++) begin
            add_entry(ram_base + b * bank_stride + 32'h10, 4'h0, '0, 32'hcafe_0000 + b, 1'b1);
        end
        // Byte lane merges
        add_entry(ram_base + 32'h20, 4'b1111, 32'h1122_3344, '0, 1'b1);
        add_entry(ram_base + 32'h20, 4'b0101, 32'haabb_ccdd, '0, 1'b1);
        add_entry(ram_base + 32'h20, 4'b0000, '0, 32'h11bb_33dd, 1'b1);
        add_entry(ram_base + 32'h20, 4'b1000, 32'h9900_0000, '0, 1'b1);
        add_entry(ram_base + 32'h20, 4'b0000, '0, 32'h99bb_33dd, 1'b1);
        // Framebuffer takes the whole word on any strobe
        add_entry(led_fb_addr, 4'b1111, 32'h1234_5678, '0, 1'b1);
        add_entry(led_fb_addr, 4'b0000, '0, 32'h1234_5678, 1'b1);
        add_entry(led_fb_addr, 4'b0100, 32'hdead_beef, '0, 1'b1);
        add_entry(led_fb_addr, 4'b0000, '0, 32'hdead_beef, 1'b1);
        // Unmapped addresses
        add_entry(32'h0000_0100, 4'b0000, '0, '0, 1'b1);
        add_entry(32'h0003_0000, 4'b1111, 32'h5555_aaaa, '0, 1'b1);
        add_entry(32'h0003_0000, 4'b0000, '0, '0, 1'b1);
        add_entry(ram_base + num_ram_banks * bank_stride, 4'b0000, '0, '0, 1'b1);
        add_entry(led_fb_addr + 4, 4'b0000, '0, '0, 1'b1);
        // Random words spread over all banks and read back against the model
        for (int k = 0; k < num_random; k++) begin
            state = lcg_next(state);
            rand_addr[k] = ram_base + (k % num_ram_banks) * bank_stride +
                           (((state >> 12) % bank_words) << 2);
            state = lcg_next(state);
            add_entry(rand_addr[k], 4'hf, state, '0, 1'b1);
        end
        for (int k = 0; k < num_random; k++) begin
            add_entry(rand_addr[k], 4'h0, '0, '0, 1'b0);
        end
    endtask

    // Starts on a falling edge and ends on the falling edge after the ready cycle
    task automatic run_test(input int n);
        int waited;
        bit got;
        int errs_before;
        waited      = 0;
        got         = 1'b0;
        errs_before = error_total();
        iomem_valid = 1'b1;
        iomem_addr  = tests[n].addr;
        iomem_wstrb = tests[n].wstrb;
        iomem_wdata = tests[n].wdata;
        exp_check   = tests[n].check;
        exp_rdata   = tests[n].rdata;
        while (!got && waited < max_wait_cycles) begin
            @(negedge clk);
            waited++;
            got = iomem_ready;
        end
        if (!got) begin
            $display("no ready for test %0d within %0d cycles", n, max_wait_cycles);
        end
        @(negedge clk);
        if (!got || error_total() != errs_before) begin
            fail_count++;
        end
        $display("test %0d %s addr %h strobe %b: %s", n,
                 tests[n].wstrb == '0 ? "read " : "write", tests[n].addr, tests[n].wstrb,
                 (got && error_total() == errs_before) ? "pass" : "error");
    endtask

    // ------------------------------
    // Main sequence and watchdog
    // ------------------------------

    initial begin
        rst_n       = 1'b0;
        iomem_valid = 1'b0;
        iomem_wstrb = '0;
        iomem_addr  = '0;
        iomem_wdata = '0;
        exp_check   = 1'b0;
        exp_rdata   = '0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // Idle cycles with no ready expected
        repeat (3) @(negedge clk);
        for (int i = 0; i < tests.size(); i++) begin
            run_test(i);
        end
        iomem_valid = 1'b0;
        iomem_wstrb = '0;
        exp_check   = 1'b0;
        repeat (3) @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests.size(),
                 tests.size() - fail_count, fail_count, error_total());
        if (fail_count == 0 && error_total() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_built);
        repeat (tests.size() * 4 + margin_cycles) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", tests.size() * 4 + margin_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
verilog/soc_map_pkg.sv
verilog/iomem_pkg.sv
verilog/iomem_if.sv
verilog/iomem_decoder.sv
verilog/ram_bank.sv
verilog/led_fb_reg.sv
verilog/iomem_resp_merge.sv
verilog/soc_iomem.sv
bench/soc_iomem_checker.sv
bench/soc_iomem_assert.sv
bench/tb_soc_iomem.sv
